/* mips16_core.f */
design/mips16_pkg.sv
design/mips16_fetch.sv
design/mips16_decode.sv
design/mips16_regfile.sv
design/mips16_execute.sv
design/mips16_result.sv
design/mips16_core.sv
bench/tb_clock.sv
bench/tb_mips16_core.sv

/* Makefile */
# verilator flow for the mips16 core and its testbench

VERILATOR  ?= verilator
TOP        ?= tb_mips16_core
RTL_TOP    ?= mips16_core
FILELIST   ?= mips16_core.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --assert
PASS_TEXT  ?= Simulation PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

# rtl only, the testbench is checked when it is built
lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(filter design/%,$(SOURCES))

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/tb_mips16_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mips16_core import mips16_pkg::*; ();

	localparam int    clk_period   = 4;    // ns, same as tb_clock
	localparam int    reset_len    = 10;   // cycles per reset pulse
	localparam int    test_limit   = 400;  // cycles allowed per program
	localparam int    drain_cycles = 8;    // quiet time after the last write
	localparam int    test_count   = 5;
	localparam int    watchdog_ns  =
		(reset_len + test_count * (reset_len + test_limit + drain_cycles + 4)) * clk_period;
	localparam word_t halt_word    = 16'hc03f; // bz r0, -1 spins on itself

	logic  clk;
	logic  rst;
	logic  rst_req;
	pc_t   fetch_pc;
	word_t instruction;
	wb_t   writeback;

	word_t  imem [256];              // instruction memory
	int     imem_len;
	word_t  model_regs [reg_count];  // reference model state
	word_t  model_mem [dmem_words];
	wb_t    expected [$];            // register writes in program order
	integer seed;
	int     pass_count;
	int     fail_count;
	int     errors;                  // current test only

	tb_clock i_tb_clock (
		.rst_req (rst_req),
		.clk     (clk),
		.rst     (rst)
	);

	mips16_core i_mips16_core (
		.clk         (clk),
		.rst         (rst),
		.fetch_pc    (fetch_pc),
		.instruction (instruction),
		.writeback   (writeback)
	);

	// imem answers the pc a little after each edge
	initial begin
		instruction = nop_word;
		forever begin
			@(posedge clk);
			#1;
			instruction = imem[fetch_pc];
		end
	end

	function automatic word_t encode_reg(opcode_e op, int rd, int rs1, int rs2);
		return {op, rd[2:0], rs1[2:0], rs2[2:0], 3'b000};
	endfunction

	function automatic word_t encode_imm(opcode_e op, int rd, int rs1, int imm);
		return {op, rd[2:0], rs1[2:0], imm[5:0]};
	endfunction

	function automatic void clear_imem();
		for (int a = 0; a < 256; a++) begin
			imem[a] = {4'hf, 4'h0, a[7:0]}; // opcode 15 runs as a nop
		end
		imem_len = 0;
	endfunction

	function automatic void put_instr(word_t w);
		imem[imem_len[7:0]] = w;
		imem_len++;
	endfunction

	function automatic word_t model_read(reg_addr_t r);
		return (r == 3'd0) ? 16'h0000 : model_regs[r];
	endfunction

	// alu by the isa rules, shift amount is the whole operand
	function automatic word_t model_alu(logic [3:0] op, word_t a, word_t b);
		case (op)
			op_add:  return a + b;
			op_sub:  return a - b;
			op_and:  return a & b;
			op_or:   return a | b;
			op_xor:  return a ^ b;
			op_sl:   return (b >= 16) ? 16'h0000 : a << b[3:0];
			op_sr:   return (b >= 16) ? {16{a[15]}} : word_t'($signed(a) >>> b[3:0]);
			op_sru:  return (b >= 16) ? 16'h0000 : a >> b[3:0];
			default: return 16'h0000;
		endcase
	endfunction

	function automatic void record_write(reg_addr_t rd, word_t data);
		wb_t w;
		w.en   = 1'b1;
		w.dest = rd;
		w.data = data;
		expected.push_back(w);
		model_regs[rd] = data; // r0 kept but read as zero
	endfunction

	// runs imem in program order up to the halt word
	task automatic run_reference();
		pc_t   pc;
		pc_t   next;
		pc_t   target;
		logic  redirect;  // taken branch waiting out its delay slot
		logic  take;
		word_t ir;
		word_t imm;
		word_t sum;
		int    steps;
		expected.delete();
		for (int r = 0; r < reg_count; r++) begin
			model_regs[r] = 16'h0000;
		end
		pc       = 8'd0;
		target   = 8'd0;
		redirect = 1'b0;
		steps    = 0;
		while (imem[pc] !== halt_word && steps < 4 * test_limit) begin
			ir   = imem[pc];
			imm  = {{10{ir[5]}}, ir[5:0]};
			sum  = model_read(ir[8:6]) + imm; // ld/st address
			take = 1'b0;
			case (ir[15:12])
				op_add, op_sub, op_and, op_or, op_xor, op_sl, op_sr, op_sru:
					record_write(ir[11:9], model_alu(ir[15:12], model_read(ir[8:6]),
						model_read(ir[5:3])));
				op_addi: record_write(ir[11:9], sum);
				op_ld:   record_write(ir[11:9], model_mem[sum[7:0]]);
				op_st:   model_mem[sum[7:0]] = model_read(ir[11:9]);
				op_bz:   take = (ir[11:9] == branch_z_cond) && (model_read(ir[8:6]) == 16'h0000);
				default: ;  // nop class
			endcase
			next     = redirect ? target : pc + 8'd1;
			redirect = take;
			target   = pc + 8'd1 + imm[7:0];
			pc       = next;
			steps++;
		end
	endtask

	task automatic pulse_reset();
		@(posedge clk);
		#1;
		rst_req = 1'b1;
		repeat (reset_len) @(posedge clk);
		#1;
		rst_req = 1'b0;
	endtask

	// reset, collect the write-backs and compare them in order
	task automatic run_program(input string name);
		wb_t got;
		int  seen;
		int  cycles;
		errors = 0;
		pulse_reset();
		// core state straight out of reset, before the first edge
		if (fetch_pc !== 8'h00) begin
			$display("Error: %s fetch_pc after reset expected %h got %h",
				name, 8'h00, fetch_pc);
			errors++;
		end
		if (writeback.en !== 1'b0) begin
			$display("Error: %s writeback.en after reset expected %h got %h",
				name, 1'b0, writeback.en);
			errors++;
		end
		run_reference();
		seen   = 0;
		cycles = 0;
		while (seen < expected.size() && cycles < test_limit) begin
			@(negedge clk);
			cycles++;
			if (writeback.en === 1'b1) begin
				got = writeback;
				if (got.dest !== expected[seen].dest) begin
					$display("Error: %s write %0d writeback.dest expected %h got %h",
						name, seen, expected[seen].dest, got.dest);
					errors++;
				end
				if (got.data !== expected[seen].data) begin
					$display("Error: %s write %0d writeback.data expected %h got %h",
						name, seen, expected[seen].data, got.data);
					errors++;
				end
				seen++;
			end
		end
		if (seen < expected.size()) begin
			$display("%s: only %0d of %0d register writes came out within %0d cycles",
				name, seen, expected.size(), test_limit);
			errors++;
		end
		repeat (drain_cycles) begin
			@(negedge clk);
			if (writeback.en === 1'b1) begin
				$display("%s: a write to r%0d came after the program had finished",
					name, writeback.dest);
				errors++;
			end
		end
		if (errors == 0) begin
			pass_count++;
			$display("%s: ok, %0d writes", name, expected.size());
		end else begin
			fail_count++;
			$display("%s: failed with %0d errors", name, errors);
		end
	endtask

	task automatic alu_ops();
		int v;
		clear_imem();
		v = $random(seed);
		put_instr(encode_imm(op_addi, 1, 0, v));            // random small operands
		v = $random(seed);
		put_instr(encode_imm(op_addi, 2, 0, v));
		v = $random(seed);
		put_instr(encode_imm(op_addi, 3, 0, v & 15));       // shift below 16
		put_instr(encode_imm(op_addi, 4, 0, 16 + (v & 15))); // shift 16 and up
		put_instr(encode_imm(op_addi, 5, 0, -1 - ((v >> 8) & 15))); // negative
		put_instr(encode_reg(op_add, 6, 1, 2));
		put_instr(encode_reg(op_sub, 6, 1, 2));
		put_instr(encode_reg(op_and, 6, 1, 2));
		put_instr(encode_reg(op_or, 6, 1, 2));
		put_instr(encode_reg(op_xor, 6, 1, 2));
		put_instr(encode_reg(op_sl, 7, 1, 3));
		put_instr(encode_reg(op_sr, 7, 5, 3));
		put_instr(encode_reg(op_sru, 7, 5, 3));
		put_instr(encode_reg(op_sl, 6, 1, 4));
		put_instr(encode_reg(op_sr, 6, 5, 4));               // all sign bits
		put_instr(encode_reg(op_sru, 6, 5, 4));
		put_instr(halt_word);
		run_program("alu_ops");
	endtask

	task automatic dependence_chain();
		clear_imem();
		put_instr(encode_imm(op_addi, 1, 0, 5));
		put_instr(encode_reg(op_add, 2, 1, 1));
		put_instr(encode_reg(op_sub, 3, 2, 1));
		put_instr(encode_reg(op_sl, 4, 3, 1));
		put_instr(encode_reg(op_add, 0, 4, 2)); // r0 written, must stay zero
		put_instr(encode_reg(op_or, 5, 0, 2));
		put_instr(encode_imm(op_addi, 0, 0, 7));
		put_instr(encode_imm(op_addi, 6, 0, -1));
		put_instr(encode_reg(op_xor, 7, 6, 4));
		put_instr(halt_word);
		run_program("dependence_chain");
	endtask

	task automatic store_load();
		clear_imem();
		put_instr(encode_imm(op_addi, 1, 0, 20));
		put_instr(encode_imm(op_addi, 2, 0, -13));
		put_instr(encode_reg(op_xor, 3, 1, 2));
		put_instr(encode_imm(op_addi, 4, 0, 30));
		put_instr(encode_imm(op_st, 3, 4, -5)); // mem[25]
		put_instr(encode_imm(op_ld, 5, 4, -5));
		put_instr(encode_reg(op_sub, 6, 1, 2));
		put_instr(encode_imm(op_st, 6, 0, -3)); // wraps to mem[253]
		put_instr(encode_imm(op_ld, 7, 0, -3));
		put_instr(halt_word);
		run_program("store_load");
	endtask

	task automatic branch_paths();
		clear_imem();
		put_instr(encode_imm(op_addi, 1, 0, 0));
		put_instr(encode_imm(op_addi, 2, 0, 9));
		put_instr(encode_imm(op_bz, 0, 1, 3));   // taken, lands on 6
		put_instr(encode_imm(op_addi, 3, 0, 11)); // delay slot
		put_instr(encode_imm(op_addi, 4, 0, 22)); // skipped
		put_instr(encode_imm(op_addi, 5, 0, 23)); // skipped
		put_instr(encode_imm(op_addi, 6, 0, 12));
		put_instr(encode_imm(op_bz, 0, 2, 4));   // r2 nonzero, falls through
		put_instr(encode_imm(op_addi, 4, 0, 13));
		put_instr(encode_imm(op_addi, 5, 0, 14));
		put_instr(encode_imm(op_bz, 1, 0, 2));   // rd field nonzero, no branch
		put_instr(encode_imm(op_addi, 7, 0, 15));
		put_instr(halt_word);
		run_program("branch_paths");
	endtask

	task automatic counting_loop();
		clear_imem();
		put_instr(encode_imm(op_addi, 1, 0, 3 + ($random(seed) & 3)));
		put_instr(encode_imm(op_addi, 2, 0, 0));
		put_instr(encode_reg(op_add, 2, 2, 1));  // loop top
		put_instr(encode_imm(op_addi, 1, 1, -1));
		put_instr(encode_imm(op_bz, 0, 1, 3));   // exit to 8
		put_instr(encode_imm(op_addi, 3, 3, 1));
		put_instr(encode_imm(op_bz, 0, 0, -5));  // back to 2
		put_instr(encode_imm(op_addi, 4, 4, 1));
		put_instr(encode_imm(op_st, 2, 0, 8));
		put_instr(encode_imm(op_ld, 5, 0, 8));
		put_instr(halt_word);
		run_program("counting_loop");
	endtask

	initial begin
		seed       = 32'hf138e5b9;
		rst_req    = 1'b0;
		pass_count = 0;
		fail_count = 0;
		clear_imem();
		alu_ops();
		dependence_chain();
		store_load();
		branch_paths();
		counting_loop();
		$display("tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// hard stop if a program never drains
	initial begin
		#(watchdog_ns);
		$display("watchdog: run did not finish within %0d ns and was stopped", watchdog_ns);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
	input  logic rst_req,  // extra reset pulses from the test sequence
	output logic clk,
	output logic rst
);

	localparam int period       = 4;  // ns
	localparam int reset_cycles = 10;

	logic start_rst;

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// power-on reset, released just after an edge
	initial begin
		start_rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#1;
		start_rst = 1'b0;
	end

	assign rst = start_rst || rst_req;

endmodule

`default_nettype wire

/* design/mips16_core.sv */
`timescale 1ns/1ns
`default_nettype none

module mips16_core import mips16_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	output pc_t   fetch_pc,
	input  word_t instruction,  // returned in the same cycle as fetch_pc
	output wb_t   writeback     // one retired register write per enabled cycle
);

	logic      stall_n;
	logic      branch_taken;
	imm_t      branch_offset;

	reg_addr_t rd_addr_1;
	reg_addr_t rd_addr_2;
	word_t     rd_data_1;
	word_t     rd_data_2;

	id_ex_t    id_ex;
	ex_mem_t   ex_mem;

	reg_addr_t ex_dest;
	reg_addr_t mem_dest;
	reg_addr_t wb_dest;

	// destinations seen by the hazard check, zero if not writing
	assign ex_dest  = id_ex.wr_en  ? id_ex.dest     : '0;
	assign mem_dest = ex_mem.wr_en ? ex_mem.dest    : '0;
	assign wb_dest  = writeback.en ? writeback.dest : '0;

	mips16_fetch i_mips16_fetch (
		.clk           (clk),
		.rst           (rst),
		.stall_n       (stall_n),
		.branch_taken  (branch_taken),
		.branch_offset (branch_offset),
		.fetch_pc      (fetch_pc)
	);

	mips16_decode i_mips16_decode (
		.clk           (clk),
		.rst           (rst),
		.instruction   (instruction),
		.rd_addr_1     (rd_addr_1),
		.rd_addr_2     (rd_addr_2),
		.rd_data_1     (rd_data_1),
		.rd_data_2     (rd_data_2),
		.ex_dest       (ex_dest),
		.mem_dest      (mem_dest),
		.wb_dest       (wb_dest),
		.stall_n       (stall_n),
		.branch_taken  (branch_taken),
		.branch_offset (branch_offset),
		.id_ex         (id_ex)
	);

	mips16_regfile i_mips16_regfile (
		.clk       (clk),
		.rst       (rst),
		.wr        (writeback),
		.rd_addr_1 (rd_addr_1),
		.rd_addr_2 (rd_addr_2),
		.rd_data_1 (rd_data_1),
		.rd_data_2 (rd_data_2)
	);

	mips16_execute i_mips16_execute (
		.clk    (clk),
		.rst    (rst),
		.id_ex  (id_ex),
		.ex_mem (ex_mem)
	);

	mips16_result i_mips16_result (
		.clk       (clk),
		.rst       (rst),
		.ex_mem    (ex_mem),
		.writeback (writeback)
	);

endmodule

`default_nettype wire

/* design/mips16_result.sv */
`timescale 1ns/1ns
`default_nettype none

module mips16_result import mips16_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  ex_mem_t ex_mem,
	output wb_t     writeback
);

	word_t     dmem [dmem_words];
	mem_addr_t mem_addr;
	word_t     load_data;

	// write-back stage register
	word_t     wb_alu;
	word_t     wb_load;
	logic      wb_en;
	reg_addr_t wb_dest;
	logic      wb_ld_sel;

	assign mem_addr = ex_mem.alu_result[$bits(mem_addr_t)-1:0]; // low bits only

	// data memory, synchronous write, combinational read
	always_ff @(posedge clk) begin
		if (ex_mem.st_en) begin
			dmem[mem_addr] <= ex_mem.st_data;
		end
	end

	assign load_data = dmem[mem_addr];

	// payload and control
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wb_alu    <= '0;
			wb_load   <= '0;
			wb_en     <= 1'b0;
			wb_dest   <= '0;
			wb_ld_sel <= 1'b0;
		end else begin
			wb_alu    <= ex_mem.alu_result;
			wb_load   <= load_data;
			wb_en     <= ex_mem.wr_en;
			wb_dest   <= ex_mem.dest;
			wb_ld_sel <= ex_mem.ld_sel;
		end
	end

	assign writeback.en   = wb_en;
	assign writeback.dest = wb_dest;
	assign writeback.data = wb_ld_sel ? wb_load : wb_alu; // load or alu

	// a store never also writes a register
	assert property (@(posedge clk) disable iff (rst) !(ex_mem.st_en && ex_mem.wr_en));

endmodule

`default_nettype wire

/* design/mips16_execute.sv */
`timescale 1ns/1ns
`default_nettype none

module mips16_execute import mips16_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  id_ex_t  id_ex,
	output ex_mem_t ex_mem
);

	word_t a;
	word_t b;
	word_t result;

	assign a = id_ex.src1;
	assign b = id_ex.src2;

	// alu
	// shift amount is the full 16-bit operand, 16 and up empties the word
	always_comb begin
		case (id_ex.alu_op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_xor: result = a ^ b;
			alu_sl:  result = a << b;
			alu_sr:  result = word_t'($signed(a) >>> b); // sign fill
			alu_sru: result = a >> b;                     // zero fill
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ex_mem <= '0;
		end else begin
			ex_mem.alu_result <= result;
			ex_mem.st_en      <= id_ex.st_en;
			ex_mem.st_data    <= id_ex.st_data;
			ex_mem.wr_en      <= id_ex.wr_en;
			ex_mem.dest       <= id_ex.dest;
			ex_mem.ld_sel     <= id_ex.ld_sel;
		end
	end

endmodule

`default_nettype wire

/* design/mips16_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module mips16_regfile import mips16_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  wb_t       wr,         // from write-back
	input  reg_addr_t rd_addr_1,
	input  reg_addr_t rd_addr_2,
	output word_t     rd_data_1,
	output word_t     rd_data_2
);

	word_t regs [reg_count];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.en) begin
			regs[wr.dest] <= wr.data; // r0 may be written, never seen
		end
	end

	// r0 reads zero
	assign rd_data_1 = (rd_addr_1 == '0) ? '0 : regs[rd_addr_1];
	assign rd_data_2 = (rd_addr_2 == '0) ? '0 : regs[rd_addr_2];

endmodule

`default_nettype wire

/* design/mips16_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module mips16_decode import mips16_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  word_t     instruction,
	output reg_addr_t rd_addr_1,
	output reg_addr_t rd_addr_2,
	input  word_t     rd_data_1,
	input  word_t     rd_data_2,
	input  reg_addr_t ex_dest,    // zero when that stage does not write
	input  reg_addr_t mem_dest,
	input  reg_addr_t wb_dest,
	output logic      stall_n,
	output logic      branch_taken,
	output imm_t      branch_offset,
	output id_ex_t    id_ex
);

	word_t     ir;
	opcode_e   ir_op;
	reg_addr_t ir_rd;
	reg_addr_t ir_rs1;
	reg_addr_t ir_rs2;
	imm_t      ir_imm;
	word_t     imm_ext;

	logic      is_st;
	logic      is_bz;
	logic      src1_live;
	logic      src2_live;
	logic      hit_1;
	logic      hit_2;

	alu_op_e   alu_op;
	logic      wr_en;
	logic      ld_sel;
	logic      use_imm;
	id_ex_t    id_ex_next;

	// instruction register, frozen during a stall
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ir <= nop_word;
		end else if (stall_n) begin
			ir <= instruction;
		end
	end

	assign ir_op   = opcode_e'(ir[15:12]); // 13..15 hit the default arm below
	assign ir_rd   = ir[11:9];
	assign ir_rs1  = ir[8:6];
	assign ir_rs2  = ir[5:3];
	assign ir_imm  = ir[5:0];
	assign imm_ext = {{($bits(word_t) - $bits(imm_t)){ir_imm[5]}}, ir_imm};

	assign is_st = (ir_op == op_st);
	assign is_bz = (ir_op == op_bz);

	// store data comes out of port 2 by the rd field
	assign rd_addr_1 = ir_rs1;
	assign rd_addr_2 = is_st ? ir_rd : ir_rs2;

	// which register reads matter for the hazard check
	always_comb begin
		src1_live = 1'b0;
		src2_live = 1'b0;
		case (ir_op)
			op_add, op_sub, op_and, op_or, op_xor, op_sl, op_sr, op_sru, op_st: begin
				src1_live = 1'b1;
				src2_live = 1'b1;
			end
			op_addi, op_ld, op_bz: src1_live = 1'b1; // no source 2
			default: ;                               // nop class reads nothing
		endcase
	end

	// raw hazard on a live nonzero source against ex, mem, wb
	assign hit_1 = src1_live && (rd_addr_1 != '0) &&
		(rd_addr_1 == ex_dest || rd_addr_1 == mem_dest || rd_addr_1 == wb_dest);
	assign hit_2 = src2_live && (rd_addr_2 != '0) &&
		(rd_addr_2 == ex_dest || rd_addr_2 == mem_dest || rd_addr_2 == wb_dest);
	assign stall_n = !(hit_1 || hit_2);

	// control decode
	always_comb begin
		alu_op  = alu_add;
		wr_en   = 1'b0;
		ld_sel  = 1'b0;
		use_imm = 1'b0;
		case (ir_op)
			op_add: begin
				alu_op = alu_add;
				wr_en  = 1'b1;
			end
			op_sub: begin
				alu_op = alu_sub;
				wr_en  = 1'b1;
			end
			op_and: begin
				alu_op = alu_and;
				wr_en  = 1'b1;
			end
			op_or: begin
				alu_op = alu_or;
				wr_en  = 1'b1;
			end
			op_xor: begin
				alu_op = alu_xor;
				wr_en  = 1'b1;
			end
			op_sl: begin
				alu_op = alu_sl;
				wr_en  = 1'b1;
			end
			op_sr: begin
				alu_op = alu_sr;
				wr_en  = 1'b1;
			end
			op_sru: begin
				alu_op = alu_sru;
				wr_en  = 1'b1;
			end
			op_addi: begin
				wr_en   = 1'b1;
				use_imm = 1'b1;
			end
			op_ld: begin
				wr_en   = 1'b1;
				ld_sel  = 1'b1;
				use_imm = 1'b1;  // address = rs1 + imm
			end
			op_st:   use_imm = 1'b1;
			default: ;           // nop, bz and 13..15 write nothing
		endcase
	end

	always_comb begin
		id_ex_next.alu_op  = alu_op;
		id_ex_next.src1    = rd_data_1;
		id_ex_next.src2    = use_imm ? imm_ext : rd_data_2;
		id_ex_next.st_en   = is_st;
		id_ex_next.st_data = rd_data_2;
		id_ex_next.wr_en   = wr_en;
		id_ex_next.dest    = ir_rd;
		id_ex_next.ld_sel  = ld_sel;
	end

	// a stalled cycle pushes an all-zero nop bubble
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			id_ex <= '0;
		end else begin
			id_ex <= stall_n ? id_ex_next : '0;
		end
	end

	// branch if zero, only when the operand is settled
	assign branch_taken  = stall_n && is_bz && (ir_rd == branch_z_cond) && (rd_data_1 == '0);
	assign branch_offset = ir_imm;

	// decoded op, operands and destination all known once out of reset
	assert property (@(posedge clk) disable iff (rst) !$isunknown(id_ex));

endmodule

`default_nettype wire

/* design/mips16_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module mips16_fetch import mips16_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic stall_n,       // low holds the pc
	input  logic branch_taken,
	input  imm_t branch_offset,
	output pc_t  fetch_pc
);

	pc_t branch_step;

	// sign-extend the 6-bit offset to pc width
	assign branch_step = {{($bits(pc_t) - $bits(imm_t)){branch_offset[5]}}, branch_offset};

	// pc already points past the branch, so +imm lands on branch + 1 + imm
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fetch_pc <= '0;
		end else if (stall_n) begin
			fetch_pc <= branch_taken ? fetch_pc + branch_step : fetch_pc + pc_t'(1);
		end
	end

	// decode must not redirect while it is frozen
	assert property (@(posedge clk) disable iff (rst) branch_taken |-> stall_n);

endmodule

`default_nettype wire

/* design/mips16_pkg.sv */
`default_nettype none

package mips16_pkg;

	// widths with a meaning
	typedef logic [15:0] word_t;     // register, alu and memory data
	typedef logic [2:0]  reg_addr_t; // r0..r7
	typedef logic [5:0]  imm_t;      // signed immediate, bits 5..0 of the word
	typedef logic [7:0]  pc_t;       // instruction address
	typedef logic [7:0]  mem_addr_t; // data memory address

	localparam word_t     nop_word      = 16'h0000; // all-zero instruction
	localparam int        reg_count     = 8;
	localparam int        dmem_words    = 256;
	localparam reg_addr_t branch_z_cond = 3'd0; // rd field of a branch-if-zero

	// opcode field, bits 15..12; 13..15 fall to nop
	typedef enum logic [3:0] {
		op_nop  = 4'd0,
		op_add  = 4'd1,
		op_sub  = 4'd2,
		op_and  = 4'd3,
		op_or   = 4'd4,
		op_xor  = 4'd5,
		op_sl   = 4'd6,
		op_sr   = 4'd7,  // arithmetic
		op_sru  = 4'd8,  // logical
		op_addi = 4'd9,
		op_ld   = 4'd10,
		op_st   = 4'd11,
		op_bz   = 4'd12
	} opcode_e;

	// alu function, 3 bits so add doubles as the idle op of a bubble
	typedef enum logic [2:0] {
		alu_add = 3'd0,  // zero code, a bubble adds 0 + 0
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_sl  = 3'd5,
		alu_sr  = 3'd6,
		alu_sru = 3'd7
	} alu_op_e;

	// one register write, 20 bits
	typedef struct packed {
		logic      en;
		reg_addr_t dest;
		word_t     data;
	} wb_t;

	// decode to execute, 57 bits
	typedef struct packed {
		alu_op_e   alu_op;
		word_t     src1;
		word_t     src2;    // register or sign-extended imm
		logic      st_en;
		word_t     st_data;
		logic      wr_en;
		reg_addr_t dest;
		logic      ld_sel;  // write back load data instead of alu result
	} id_ex_t;

	// execute to result, 38 bits
	typedef struct packed {
		word_t     alu_result;
		logic      st_en;
		word_t     st_data;
		logic      wr_en;
		reg_addr_t dest;
		logic      ld_sel;
	} ex_mem_t;

endpackage

`default_nettype wire
